//--- logic/engine_cfg_pkg.sv
package engine_cfg_pkg;

	// Host register map, byte offsets
	localparam int CSB_ADDR_W = 8;

	localparam logic [CSB_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [CSB_ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [CSB_ADDR_W-1:0] REG_CFG = 8'h08;
	localparam logic [CSB_ADDR_W-1:0] REG_BIAS = 8'h0C;
	localparam logic [CSB_ADDR_W-1:0] REG_WINDOWS = 8'h10;

	// Anything else counts as idle
	typedef enum logic [2:0] {
		OP_CONV = 3'd1,
		OP_MAXPOOL = 3'd2,
		OP_AVGPOOL = 3'd3
	} op_e;

	typedef struct packed {
		logic [14:0] rsvd_hi;
		logic relu_en;
		logic [7:0] kernel_size;
		logic [4:0] rsvd_lo;
		op_e op;
	} conv_cfg_s;

	typedef struct packed {
		logic [11:0] rsvd_hi;
		logic [3:0] avg_shift;
		logic [7:0] kernel_size;
		logic [4:0] rsvd_lo;
		op_e op;
	} pool_cfg_s;

	// Same CFG word, upper bits mean different things per op
	typedef union packed {
		conv_cfg_s conv;
		pool_cfg_s pool;
	} cfg_word_u;

endpackage

//--- logic/engine_data_pkg.sv
package engine_data_pkg;

	// Headroom above the full product width
	localparam int GUARD_W = 8;

	// Sum of up to 255 words grows by 8 bits
	localparam int SUM_GUARD_W = 8;

	// MAC accumulator: full product plus guard bits
	function automatic int mac_acc_w(input int data_w);
		return 2 * data_w + GUARD_W;
	endfunction

	// Pooling running sum
	function automatic int pool_sum_w(input int data_w);
		return data_w + SUM_GUARD_W;
	endfunction

endpackage

//--- logic/csb_axil_slave.sv
`timescale 1ns/1ps

module csb_axil_slave import engine_cfg_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_awvalid,
	output logic o_awready,
	input  logic [CSB_ADDR_W-1:0] i_awaddr,
	input  logic i_wvalid,
	output logic o_wready,
	input  logic [31:0] i_wdata,
	input  logic [3:0] i_wstrb,
	output logic o_bvalid,
	input  logic i_bready,
	output logic [1:0] o_bresp,
	input  logic i_arvalid,
	output logic o_arready,
	input  logic [CSB_ADDR_W-1:0] i_araddr,
	output logic o_rvalid,
	input  logic i_rready,
	output logic [31:0] o_rdata,
	output logic [1:0] o_rresp,
	input  logic i_busy,
	input  logic i_done,
	output logic o_start,
	output cfg_word_u o_cfg,
	output logic [DATA_W-1:0] o_bias,
	output logic [CNT_W-1:0] o_windows
);

	logic wr_fire;
	logic rd_fire;
	logic op_ok;
	logic start_ok;
	logic done_r;

	function automatic logic [31:0] strb_merge(
		input logic [31:0] old_val,
		input logic [31:0] new_val,
		input logic [3:0] strb
	);
		logic [31:0] merged;
		for (int b = 0; b < 4; b++) begin
			merged[8*b +: 8] = strb[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
		end
		return merged;
	endfunction

	// Address and data taken together, one write at a time
	assign o_awready = !o_bvalid && i_awvalid && i_wvalid;
	assign o_wready = o_awready;
	assign wr_fire = o_awready;
	assign o_bresp = 2'b00;

	assign o_arready = !o_rvalid;
	assign rd_fire = i_arvalid && o_arready;
	assign o_rresp = 2'b00;

	assign op_ok = o_cfg.conv.op inside {OP_CONV, OP_MAXPOOL, OP_AVGPOOL};
	assign start_ok = wr_fire && (i_awaddr == REG_CTRL) && i_wstrb[0] && i_wdata[0]
		&& !i_busy && op_ok && (o_cfg.conv.kernel_size != 8'd0) && (o_windows != '0);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
			o_start <= 1'b0;
			done_r <= 1'b0;
			o_cfg <= '0;
			o_bias <= '0;
			o_windows <= '0;
		end else begin
			o_start <= start_ok;
			if (wr_fire) begin
				o_bvalid <= 1'b1;
			end else if (i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
			// Sticky until the next job starts
			if (o_start) begin
				done_r <= 1'b0;
			end else if (i_done) begin
				done_r <= 1'b1;
			end
			// Job parameters frozen while running
			if (wr_fire && !i_busy) begin
				case (i_awaddr)
					REG_CFG: o_cfg <= strb_merge(o_cfg, i_wdata, i_wstrb);
					REG_BIAS: o_bias <= DATA_W'(strb_merge(32'(o_bias), i_wdata, i_wstrb));
					REG_WINDOWS: o_windows <= CNT_W'(strb_merge(32'(o_windows), i_wdata, i_wstrb));
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			case (i_araddr)
				REG_STATUS: o_rdata <= {30'd0, done_r, i_busy};
				REG_CFG: o_rdata <= o_cfg;
				REG_BIAS: o_rdata <= 32'(o_bias);
				REG_WINDOWS: o_rdata <= 32'(o_windows);
				default: o_rdata <= 32'd0;
			endcase
		end
	end

endmodule

//--- logic/window_sequencer.sv
`timescale 1ns/1ps

module window_sequencer import engine_cfg_pkg::*; #(
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_start,
	input  cfg_word_u i_cfg,
	input  logic [CNT_W-1:0] i_windows,
	input  logic i_dat_valid,
	input  logic i_wgt_valid,
	input  logic i_slot_free,
	input  logic i_res_fire,
	output logic o_dat_ready,
	output logic o_wgt_ready,
	output logic o_beat,
	output logic o_last,
	output logic o_busy,
	output logic o_done
);

	logic [7:0] word_cnt;
	logic [CNT_W-1:0] win_cnt;
	logic [CNT_W-1:0] res_cnt;
	logic lane_pend;
	logic is_conv;
	logic all_in;
	logic take;

	assign is_conv = (i_cfg.conv.op == OP_CONV);
	assign all_in = (win_cnt == i_windows);

	// Mid-window words always flow; a new window waits until the
	// previous result has left the lane and the merge slot is free
	assign take = o_busy && !all_in
		&& ((word_cnt != 8'd0) || (i_slot_free && !lane_pend));

	// Convolution pairs data with weight, so each ready waits on the other valid
	assign o_dat_ready = take && (!is_conv || i_wgt_valid);
	assign o_wgt_ready = take && is_conv && i_dat_valid;
	assign o_beat = o_dat_ready && i_dat_valid;
	assign o_last = (word_cnt == i_cfg.conv.kernel_size - 8'd1);

	assign o_done = o_busy && i_res_fire && (res_cnt == i_windows - 1'b1);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_busy <= 1'b0;
			word_cnt <= '0;
			win_cnt <= '0;
			res_cnt <= '0;
			lane_pend <= 1'b0;
		end else begin
			lane_pend <= o_beat && o_last;
			if (i_start) begin
				o_busy <= 1'b1;
				word_cnt <= '0;
				win_cnt <= '0;
				res_cnt <= '0;
			end else begin
				if (o_done) begin
					o_busy <= 1'b0;
				end
				if (o_beat) begin
					if (o_last) begin
						word_cnt <= '0;
						win_cnt <= win_cnt + 1'b1;
					end else begin
						word_cnt <= word_cnt + 8'd1;
					end
				end
				if (i_res_fire) begin
					res_cnt <= res_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/window_mac.sv
`timescale 1ns/1ps

module window_mac import engine_data_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8,
	localparam int PROD_W = 2 * DATA_W,
	localparam int ACC_W = mac_acc_w(DATA_W)
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_beat,
	input  logic i_last,
	input  logic signed [DATA_W-1:0] i_dat,
	input  logic signed [DATA_W-1:0] i_wgt,
	input  logic signed [DATA_W-1:0] i_bias,
	output logic o_mac_valid,
	output logic signed [ACC_W-1:0] o_mac_acc
);

	logic first;
	logic signed [PROD_W-1:0] prod;
	logic signed [ACC_W-1:0] bias_ext;
	logic signed [ACC_W-1:0] base;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] sum;

	assign prod = i_dat * i_wgt;
	assign bias_ext = i_bias;

	// Bias moved up to the product scale seeds every window
	assign base = first ? (bias_ext <<< FRAC_W) : acc;
	assign sum = base + prod;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			first <= 1'b1;
			o_mac_valid <= 1'b0;
		end else begin
			o_mac_valid <= i_beat && i_last;
			if (i_beat) begin
				first <= i_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_beat) begin
			acc <= sum;
			if (i_last) begin
				o_mac_acc <= sum;
			end
		end
	end

endmodule

//--- logic/window_pool.sv
`timescale 1ns/1ps

module window_pool import engine_data_pkg::*; #(
	parameter int DATA_W = 16,
	localparam int SUM_W = pool_sum_w(DATA_W)
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_beat,
	input  logic i_last,
	input  logic signed [DATA_W-1:0] i_dat,
	output logic o_pool_valid,
	output logic signed [DATA_W-1:0] o_pool_max,
	output logic signed [SUM_W-1:0] o_pool_sum
);

	logic first;
	logic signed [DATA_W-1:0] run_max;
	logic signed [DATA_W-1:0] next_max;
	logic signed [SUM_W-1:0] run_sum;
	logic signed [SUM_W-1:0] next_sum;
	logic signed [SUM_W-1:0] dat_ext;

	assign dat_ext = i_dat;

	// First word of a window restarts both
	assign next_max = (first || (i_dat > run_max)) ? i_dat : run_max;
	assign next_sum = first ? dat_ext : run_sum + dat_ext;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			first <= 1'b1;
			o_pool_valid <= 1'b0;
		end else begin
			o_pool_valid <= i_beat && i_last;
			if (i_beat) begin
				first <= i_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_beat) begin
			run_max <= next_max;
			run_sum <= next_sum;
			if (i_last) begin
				o_pool_max <= next_max;
				o_pool_sum <= next_sum;
			end
		end
	end

endmodule

//--- logic/result_merge.sv
`timescale 1ns/1ps

module result_merge
	import engine_cfg_pkg::*;
	import engine_data_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8,
	localparam int ACC_W = mac_acc_w(DATA_W),
	localparam int SUM_W = pool_sum_w(DATA_W)
) (
	input  logic clk,
	input  logic i_rst,
	input  cfg_word_u i_cfg,
	input  logic i_mac_valid,
	input  logic signed [ACC_W-1:0] i_mac_acc,
	input  logic i_pool_valid,
	input  logic signed [DATA_W-1:0] i_pool_max,
	input  logic signed [SUM_W-1:0] i_pool_sum,
	input  logic i_res_ready,
	output logic o_res_valid,
	output logic [DATA_W-1:0] o_res,
	output logic o_slot_free,
	output logic o_res_fire
);

	localparam logic signed [ACC_W-1:0] SAT_MAX = {{(ACC_W-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_MIN = {{(ACC_W-DATA_W+1){1'b1}}, {(DATA_W-1){1'b0}}};

	logic lane_valid;
	logic signed [ACC_W-1:0] scaled;
	logic [DATA_W-1:0] sat_val;

	assign lane_valid = (i_cfg.conv.op == OP_CONV) ? i_mac_valid : i_pool_valid;

	always_comb begin
		case (i_cfg.conv.op)
			OP_CONV: begin
				scaled = i_mac_acc >>> FRAC_W;
				if (i_cfg.conv.relu_en && (scaled < 0)) begin
					scaled = '0;
				end
			end
			OP_MAXPOOL: scaled = i_pool_max;
			OP_AVGPOOL: scaled = i_pool_sum >>> i_cfg.pool.avg_shift;
			default: scaled = '0;
		endcase
	end

	always_comb begin
		if (scaled > SAT_MAX) begin
			sat_val = SAT_MAX[DATA_W-1:0];
		end else if (scaled < SAT_MIN) begin
			sat_val = SAT_MIN[DATA_W-1:0];
		end else begin
			sat_val = scaled[DATA_W-1:0];
		end
	end

	assign o_res_fire = o_res_valid && i_res_ready;
	assign o_slot_free = !o_res_valid || i_res_ready;

	// Sequencer keeps this slot empty whenever a lane result lands
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_res_valid <= 1'b0;
		end else if (lane_valid) begin
			o_res_valid <= 1'b1;
		end else if (o_res_fire) begin
			o_res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (lane_valid) begin
			o_res <= sat_val;
		end
	end

endmodule

//--- logic/engine_top.sv
`timescale 1ns/1ps

module engine_top
	import engine_cfg_pkg::*;
	import engine_data_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8,
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic i_rst,
	input  logic i_awvalid,
	output logic o_awready,
	input  logic [CSB_ADDR_W-1:0] i_awaddr,
	input  logic i_wvalid,
	output logic o_wready,
	input  logic [31:0] i_wdata,
	input  logic [3:0] i_wstrb,
	output logic o_bvalid,
	input  logic i_bready,
	output logic [1:0] o_bresp,
	input  logic i_arvalid,
	output logic o_arready,
	input  logic [CSB_ADDR_W-1:0] i_araddr,
	output logic o_rvalid,
	input  logic i_rready,
	output logic [31:0] o_rdata,
	output logic [1:0] o_rresp,
	input  logic i_dat_valid,
	output logic o_dat_ready,
	input  logic signed [DATA_W-1:0] i_dat,
	input  logic i_wgt_valid,
	output logic o_wgt_ready,
	input  logic signed [DATA_W-1:0] i_wgt,
	output logic o_res_valid,
	input  logic i_res_ready,
	output logic [DATA_W-1:0] o_res
);

	localparam int ACC_W = mac_acc_w(DATA_W);
	localparam int SUM_W = pool_sum_w(DATA_W);

	cfg_word_u cfg;
	logic start;
	logic busy;
	logic done;
	logic beat;
	logic last;
	logic slot_free;
	logic res_fire;
	logic [DATA_W-1:0] bias;
	logic [CNT_W-1:0] windows;
	logic mac_valid;
	logic signed [ACC_W-1:0] mac_acc;
	logic pool_valid;
	logic signed [DATA_W-1:0] pool_max;
	logic signed [SUM_W-1:0] pool_sum;

	csb_axil_slave #(.DATA_W(DATA_W), .CNT_W(CNT_W)) u_csb (
		.clk, .i_rst,
		.i_awvalid, .o_awready, .i_awaddr,
		.i_wvalid, .o_wready, .i_wdata, .i_wstrb,
		.o_bvalid, .i_bready, .o_bresp,
		.i_arvalid, .o_arready, .i_araddr,
		.o_rvalid, .i_rready, .o_rdata, .o_rresp,
		.i_busy(busy), .i_done(done),
		.o_start(start), .o_cfg(cfg), .o_bias(bias), .o_windows(windows)
	);

	window_sequencer #(.CNT_W(CNT_W)) u_seq (
		.clk, .i_rst,
		.i_start(start), .i_cfg(cfg), .i_windows(windows),
		.i_dat_valid, .i_wgt_valid, .o_dat_ready, .o_wgt_ready,
		.i_slot_free(slot_free), .i_res_fire(res_fire),
		.o_beat(beat), .o_last(last), .o_busy(busy), .o_done(done)
	);

	window_mac #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) u_mac (
		.clk, .i_rst,
		.i_beat(beat), .i_last(last),
		.i_dat, .i_wgt, .i_bias(bias),
		.o_mac_valid(mac_valid), .o_mac_acc(mac_acc)
	);

	window_pool #(.DATA_W(DATA_W)) u_pool (
		.clk, .i_rst,
		.i_beat(beat), .i_last(last), .i_dat,
		.o_pool_valid(pool_valid), .o_pool_max(pool_max), .o_pool_sum(pool_sum)
	);

	result_merge #(.DATA_W(DATA_W), .FRAC_W(FRAC_W)) u_merge (
		.clk, .i_rst, .i_cfg(cfg),
		.i_mac_valid(mac_valid), .i_mac_acc(mac_acc),
		.i_pool_valid(pool_valid), .i_pool_max(pool_max), .i_pool_sum(pool_sum),
		.i_res_ready, .o_res_valid, .o_res,
		.o_slot_free(slot_free), .o_res_fire(res_fire)
	);

endmodule

//--- sim/engine_tb.sv
`timescale 1ns/1ps

module engine_tb import engine_cfg_pkg::*; ();

	localparam int DATA_W = 16;
	localparam int FRAC_W = 8;
	localparam int CNT_W = 16;
	// Four cycles per word of every window plus margin
	localparam int TIMEOUT = (9 * 4 * 2 + 9 * 4 + 16 * 4 + 9 * 6) * 4 + 2000;

	logic clk = 1'b0;
	logic i_rst;
	logic i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
	logic [7:0] i_awaddr, i_araddr;
	logic [31:0] i_wdata;
	logic [3:0] i_wstrb;
	logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
	logic [1:0] o_bresp, o_rresp;
	logic [31:0] o_rdata;
	logic i_dat_valid, i_wgt_valid, i_res_ready;
	logic signed [DATA_W-1:0] i_dat, i_wgt;
	logic o_dat_ready, o_wgt_ready, o_res_valid;
	logic [DATA_W-1:0] o_res;

	logic [15:0] dat_mem [0:127];
	logic [15:0] wgt_mem [0:127];
	int dat_pos, dat_len, wgt_pos, wgt_len;
	bit gaps_en, stall_en, pool_mode;
	logic [15:0] exp_q[$];
	logic [15:0] exp_head;
	int exp_cnt, got, cycles;
	int errors, err_mark, tests_run, tests_ok;
	string test_name;

	engine_top #(.DATA_W(DATA_W), .FRAC_W(FRAC_W), .CNT_W(CNT_W)) UUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Stream drivers and the result ready
	always @(posedge clk) begin
		if (i_dat_valid && o_dat_ready) dat_pos = dat_pos + 1;
		if (i_wgt_valid && o_wgt_ready) wgt_pos = wgt_pos + 1;
		if (!i_rst) begin
			if (!(i_dat_valid && !o_dat_ready)) begin
				if (dat_pos < dat_len && (!gaps_en || $urandom_range(3) != 0)) begin
					i_dat_valid <= 1'b1;
					i_dat <= dat_mem[dat_pos];
				end else begin
					i_dat_valid <= 1'b0;
				end
			end
			if (!(i_wgt_valid && !o_wgt_ready)) begin
				if (wgt_pos < wgt_len && (!gaps_en || $urandom_range(3) != 0)) begin
					i_wgt_valid <= 1'b1;
					i_wgt <= wgt_mem[wgt_pos];
				end else begin
					i_wgt_valid <= 1'b0;
				end
			end
			i_res_ready <= !stall_en || ($urandom_range(2) != 0);
		end
	end

	always @(posedge clk) begin
		if (!i_rst && o_res_valid && i_res_ready && exp_cnt > 0) begin
			void'(exp_q.pop_front());
			got = got + 1;
			exp_cnt = exp_q.size();
			if (exp_cnt > 0) exp_head = exp_q[0];
		end
	end

	assert property (@(posedge clk) disable iff (i_rst)
		(o_res_valid && i_res_ready) |-> (o_res == exp_head))
	else begin
		$display("mismatch %s: expected %h actual %h", test_name,
			$sampled(exp_head), $sampled(o_res));
		errors = errors + 1;
	end

	assert property (@(posedge clk) disable iff (i_rst)
		(o_res_valid && i_res_ready) |-> (exp_cnt > 0))
	else begin
		$display("%s: result handed out with none expected", test_name);
		errors = errors + 1;
	end

	assert property (@(posedge clk) disable iff (i_rst)
		(o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res)))
	else begin
		$display("%s: held result changed or dropped before it was taken", test_name);
		errors = errors + 1;
	end

	assert property (@(posedge clk) disable iff (i_rst) pool_mode |-> !o_wgt_ready)
	else begin
		$display("%s: weight ready rose during pooling", test_name);
		errors = errors + 1;
	end

	assert property (@(posedge clk) disable iff (i_rst) o_bvalid |-> (o_bresp == 2'b00))
	else begin
		$display("mismatch %s bresp: expected %h actual %h", test_name,
			2'b00, $sampled(o_bresp));
		errors = errors + 1;
	end

	assert property (@(posedge clk) disable iff (i_rst) o_rvalid |-> (o_rresp == 2'b00))
	else begin
		$display("mismatch %s rresp: expected %h actual %h", test_name,
			2'b00, $sampled(o_rresp));
		errors = errors + 1;
	end

	function automatic logic [15:0] sat16(input longint v);
		if (v > 32767) return 16'h7fff;
		if (v < -32768) return 16'h8000;
		return 16'(v);
	endfunction

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		i_awvalid <= 1'b1;
		i_awaddr <= addr;
		i_wvalid <= 1'b1;
		i_wdata <= data;
		do @(negedge clk); while (!(o_awready && o_wready));
		@(posedge clk);
		i_awvalid <= 1'b0;
		i_wvalid <= 1'b0;
		do @(negedge clk); while (!o_bvalid);
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		i_arvalid <= 1'b1;
		i_araddr <= addr;
		do @(negedge clk); while (!o_arready);
		@(posedge clk);
		i_arvalid <= 1'b0;
		do @(negedge clk); while (!o_rvalid);
		data = o_rdata;
	endtask

	task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] val;
		axi_read(addr, val);
		assert (val == exp)
		else begin
			$display("mismatch %s: expected %h actual %h", test_name, exp, val);
			errors = errors + 1;
		end
	endtask

	// Reference model fills both streams and queues the expected words
	task automatic build_job(input logic [2:0] op, input int ks, input int wins,
		input bit relu, input int shift, input logic signed [15:0] bias,
		input bit wide, input bit sat_last);
		logic signed [15:0] d;
		logic signed [15:0] w;
		longint acc;
		longint r;
		exp_q.delete();
		for (int win = 0; win < wins; win++) begin
			acc = (op == OP_CONV) ? (longint'(bias) <<< FRAC_W) : 0;
			for (int k = 0; k < ks; k++) begin
				d = wide ? 16'($urandom) : 16'($urandom_range(2047)) - 16'd1024;
				w = wide ? 16'($urandom) : 16'($urandom_range(1023)) - 16'd512;
				if (sat_last && win == wins - 1) d = 16'sh7fff;
				dat_mem[win * ks + k] = d;
				wgt_mem[win * ks + k] = w;
				if (op == OP_CONV) acc = acc + longint'(d) * longint'(w);
				else if (op == OP_AVGPOOL) acc = acc + longint'(d);
				else if (k == 0 || longint'(d) > acc) acc = longint'(d);
			end
			r = acc;
			if (op == OP_CONV) r = acc >>> FRAC_W;
			if (op == OP_CONV && relu && r < 0) r = 0;
			if (op == OP_AVGPOOL) r = acc >>> shift;
			exp_q.push_back(sat16(r));
		end
		got = 0;
		exp_cnt = exp_q.size();
		exp_head = exp_q[0];
		dat_pos = 0;
		wgt_pos = 0;
		dat_len = wins * ks;
		wgt_len = (op == OP_CONV) ? wins * ks : 0;
	endtask

	task automatic finish_test();
		tests_run = tests_run + 1;
		if (errors == err_mark) begin
			tests_ok = tests_ok + 1;
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic run_job(input string name, input logic [2:0] op, input int ks,
		input int wins, input bit relu, input int shift, input logic signed [15:0] bias,
		input bit wide, input bit sat_last, input bit gaps, input bit stalls);
		logic [31:0] cfg;
		test_name = name;
		cfg = (32'(shift) << 16) | (32'(relu) << 16) | (32'(ks) << 8) | 32'(op);
		gaps_en = gaps;
		stall_en = stalls;
		pool_mode = (op != OP_CONV);
		axi_write(REG_CFG, cfg);
		axi_write(REG_BIAS, 32'(bias));
		axi_write(REG_WINDOWS, 32'(wins));
		build_job(op, ks, wins, relu, shift, bias, wide, sat_last);
		axi_write(REG_CTRL, 32'd1);
		// Busy set and the previous done cleared
		check_reg(REG_STATUS, 32'd1);
		while (got < wins) @(negedge clk);
		check_reg(REG_STATUS, 32'd2);
		pool_mode = 1'b0;
		stall_en = 1'b0;
		finish_test();
	endtask

	initial begin
		void'($urandom(32'hbd75f62a));
		i_rst = 1'b1;
		{i_awvalid, i_wvalid, i_arvalid} = '0;
		i_bready = 1'b1;
		i_rready = 1'b1;
		i_awaddr = '0;
		i_araddr = '0;
		i_wdata = '0;
		i_wstrb = 4'hf;
		{i_dat_valid, i_wgt_valid} = '0;
		i_res_ready = 1'b1;
		i_dat = '0;
		i_wgt = '0;
		{dat_pos, dat_len, wgt_pos, wgt_len, got, exp_cnt, cycles} = '0;
		{errors, err_mark, tests_run, tests_ok} = '0;
		{gaps_en, stall_en, pool_mode} = '0;
		exp_head = '0;
		test_name = "reset";
		repeat (10) @(posedge clk);
		i_rst <= 1'b0;
		@(negedge clk);

		assert (!o_res_valid && !o_dat_ready && !o_wgt_ready && !o_bvalid && !o_rvalid)
		else begin
			$display("reset: outputs not low after reset");
			errors = errors + 1;
		end
		test_name = "reset_regs";
		check_reg(REG_STATUS, 32'd0);
		axi_write(REG_CFG, 32'h0003_0902);
		axi_write(REG_BIAS, 32'h0000_ff40);
		axi_write(REG_WINDOWS, 32'h0000_0005);
		check_reg(REG_CFG, 32'h0003_0902);
		check_reg(REG_BIAS, 32'h0000_ff40);
		check_reg(REG_WINDOWS, 32'h0000_0005);
		finish_test();

		run_job("conv", OP_CONV, 9, 4, 1'b0, 0, -16'sd384, 1'b0, 1'b0, 1'b0, 1'b0);
		run_job("conv_relu", OP_CONV, 9, 4, 1'b1, 0, -16'sd384, 1'b0, 1'b0, 1'b0, 1'b0);
		run_job("maxpool", OP_MAXPOOL, 9, 4, 1'b0, 0, 16'sd0, 1'b1, 1'b0, 1'b0, 1'b0);
		run_job("avgpool", OP_AVGPOOL, 16, 4, 1'b0, 4, 16'sd0, 1'b0, 1'b1, 1'b0, 1'b0);
		run_job("conv_stall", OP_CONV, 9, 6, 1'b0, 0, 16'sd200, 1'b1, 1'b0, 1'b1, 1'b1);

		$display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0 && tests_ok == tests_run) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
logic/engine_cfg_pkg.sv
logic/engine_data_pkg.sv
logic/csb_axil_slave.sv
logic/window_sequencer.sv
logic/window_mac.sv
logic/window_pool.sv
logic/result_merge.sv
logic/engine_top.sv
sim/engine_tb.sv
